// File: all.f
+incdir+include
src/fetch_pkg.sv
src/itcm_apb.sv
src/rvc_predecode.sv
src/if_stage.sv
src/fetch_queue.sv
src/fetch_top.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

// File: include/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first pc after reset
`define FETCH_RESET_ADDR 32'h0000_0000

// itcm depth in 32-bit words
`define ITCM_WORDS 64

// pready low cycles per access
`define ITCM_WAIT 1

// fetch queue entries
`define FQ_DEPTH 4

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch testbench with Verilator from the project root.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module fetch_tb \
  -o vfetch_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

# the ITCM loads its image by a path relative to the run directory
cp sim/prog.hex prog.hex
if [ $? -ne 0 ]; then
  echo "could not stage prog.hex"
  exit 1
fi

./obj_dir/vfetch_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// File: sim/fetch_chk.sv
`timescale 1ns/10ps

module fetch_chk (
  input logic                  clock,
  input logic                  reset,
  input fetch_pkg::apb_req_t   apb_req,
  input fetch_pkg::apb_rsp_t   apb_rsp,
  input logic                  push_valid,
  input fetch_pkg::fetch_pkt_t push_pkt,
  input logic                  full,
  input logic                  redirect_valid
);
  import fetch_pkg::*;

  int   assert_errors = 0;  // summed into the closing line
  logic cf_wait;            // control flow pushed, redirect still out

  always_ff @(posedge clock) begin
    if (reset) begin
      cf_wait <= 1'b0;
    end else if (redirect_valid) begin
      cf_wait <= 1'b0;
    end else if (push_valid && !full && push_pkt.is_cf) begin
      cf_wait <= 1'b1;
    end
  end

  // penable only follows a setup cycle
  a_setup_first: assert property (@(posedge clock) disable iff (reset)
    $rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
    else begin
      assert_errors++;
      $error("penable rose without a setup cycle");
    end

  a_paddr_aligned: assert property (@(posedge clock) disable iff (reset)
    apb_req.psel |-> (apb_req.paddr[1:0] == 2'b00))
    else begin
      assert_errors++;
      $error("paddr not word aligned");
    end

  // wait state keeps the transfer alive
  a_paddr_stable: assert property (@(posedge clock) disable iff (reset)
    (apb_req.penable && !apb_rsp.pready) |=>
      (apb_req.psel && apb_req.penable && $stable(apb_req.paddr)))
    else begin
      assert_errors++;
      $error("apb transfer changed during wait state");
    end

  a_psel_drop: assert property (@(posedge clock) disable iff (reset)
    (apb_req.penable && apb_rsp.pready) |=> !apb_req.psel)
    else begin
      assert_errors++;
      $error("psel still high after pready");
    end

  // after a control-flow push nothing moves until retire answers
  a_cf_stall: assert property (@(posedge clock) disable iff (reset)
    cf_wait |-> (!apb_req.psel && !push_valid))
    else begin
      assert_errors++;
      $error("bus or push activity while waiting for redirect");
    end

  a_push_hold: assert property (@(posedge clock) disable iff (reset)
    (push_valid && full) |=> (push_valid && $stable(push_pkt)))
    else begin
      assert_errors++;
      $error("push packet changed while queue full");
    end

endmodule

bind if_stage fetch_chk u_chk (
  .clock          (clock),
  .reset          (reset),
  .apb_req        (apb_req),
  .apb_rsp        (apb_rsp),
  .push_valid     (push_valid),
  .push_pkt       (push_pkt),
  .full           (full),
  .redirect_valid (redirect_valid)
);

// File: sim/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int aw = $clog2(`ITCM_WORDS);
  localparam addr_t end_pc = 32'h48;  // final ecall, no redirect after it
  localparam int fill_cycles = 30;    // decode idle at first so the queue fills

  logic       clock;
  logic       reset;
  logic       pkt_ready;
  logic       redirect_valid;
  addr_t      redirect_pc;
  fetch_pkt_t pkt;
  logic       pkt_valid;

  word_t      prog [`ITCM_WORDS];
  integer     seed;
  int         expected_count;
  int         accepted;
  int         cycles;
  int         redirect_num;
  int         wait_left;
  logic       redirect_pending;
  addr_t      redirect_target;
  addr_t      exp_pc;
  logic       stalled;
  fetch_pkt_t stalled_pkt;
  int         pc_errors;
  int         inst_errors;
  int         class_errors;
  int         hold_errors;
  int         count_errors;

  fetch_top uut (
    .clock          (clock),
    .reset          (reset),
    .pkt            (pkt),
    .pkt_valid      (pkt_valid),
    .pkt_ready      (pkt_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  always #4 clock = ~clock;

  function automatic half_t half_at(addr_t a);
    word_t w;
    w = prog[a[aw+1:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic word_t inst_at(addr_t a);
    half_t lo;
    lo = half_at(a);
    if (lo[1:0] == 2'b11) return {half_at(a + 32'd2), lo};
    return {16'h0, lo};
  endfunction

  function automatic logic cf_of(word_t i);
    logic [6:0] op;
    op = i[6:0];
    if (i[1:0] == 2'b01) return i[15:13] inside {3'b001, 3'b101, 3'b110, 3'b111};
    if (i[1:0] == 2'b10) return (i[15:13] == 3'b100) && (i[6:2] == 5'd0);
    if (i[1:0] == 2'b00) return 1'b0;
    return op inside {7'h6F, 7'h67, 7'h63, 7'h0F, 7'h73};
  endfunction

  // odd redirects jump where the table has an entry
  function automatic addr_t redirect_for(addr_t pc, addr_t step, int num);
    addr_t t;
    t = pc + step;
    if (num % 2 == 1) begin
      case (pc)
        32'h10: t = 32'h22;
        32'h2A: t = 32'h36;
        32'h3E: t = 32'h44;
        default: t = pc + step;
      endcase
    end
    return t;
  endfunction

  function automatic int count_expected();
    addr_t pc;
    word_t i;
    addr_t step;
    int    n;
    int    num;
    pc = `FETCH_RESET_ADDR;
    n = 0;
    num = 0;
    while (n < 100) begin
      n++;
      i = inst_at(pc);
      step = (i[1:0] == 2'b11) ? 32'd4 : 32'd2;
      if (cf_of(i)) begin
        if (pc == end_pc) break;
        pc = redirect_for(pc, step, num);
        num++;
      end else begin
        pc = pc + step;
      end
    end
    return n;
  endfunction

  task automatic accept_pkt();
    word_t exp_inst;
    logic  exp_rv16;
    logic  exp_cf;
    addr_t step;
    exp_inst = inst_at(pkt.pc);
    exp_rv16 = exp_inst[1:0] != 2'b11;
    exp_cf   = cf_of(exp_inst);
    step     = exp_rv16 ? 32'd2 : 32'd4;
    accepted++;
    assert (accepted <= expected_count) else begin
      count_errors++;
      $display("extra packet accepted beyond the predicted program at pc %h", pkt.pc);
    end
    assert (pkt.pc == exp_pc) else begin
      pc_errors++;
      $display("[ERROR] pkt.pc got %h expected %h", pkt.pc, exp_pc);
    end
    assert (pkt.inst == exp_inst) else begin
      inst_errors++;
      $display("[ERROR] pkt.inst got %h expected %h at pc %h", pkt.inst, exp_inst, pkt.pc);
    end
    assert (pkt.is_rv16 == exp_rv16 && pkt.is_cf == exp_cf) else begin
      class_errors++;
      $display("[ERROR] pkt.is_rv16/is_cf got %h/%h expected %h/%h at pc %h",
               pkt.is_rv16, pkt.is_cf, exp_rv16, exp_cf, pkt.pc);
    end
    if (exp_cf) begin
      if (pkt.pc != end_pc) begin
        redirect_target  = redirect_for(pkt.pc, step, redirect_num);
        redirect_num++;
        redirect_pending = 1'b1;
        wait_left        = 2;  // retire answers two cycles later
        exp_pc           = redirect_target;
      end
    end else begin
      exp_pc = pkt.pc + step;
    end
  endtask

  // runs at the rising edge, before registers update
  task automatic check_edge();
    if (stalled) begin
      assert (pkt_valid && pkt == stalled_pkt) else begin
        hold_errors++;
        $display("[ERROR] pkt under back-pressure got %h expected %h", pkt, stalled_pkt);
      end
    end
    stalled     = pkt_valid && !pkt_ready;
    stalled_pkt = pkt;
    if (pkt_valid && pkt_ready) begin
      accept_pkt();
    end
  endtask

  task automatic drive_inputs();
    pkt_ready      = 1'($random(seed));
    if (cycles < fill_cycles) begin
      pkt_ready = 1'b0;
    end
    redirect_valid = 1'b0;
    if (redirect_pending) begin
      wait_left--;
      if (wait_left == 0) begin
        redirect_valid   = 1'b1;
        redirect_pc      = redirect_target;
        redirect_pending = 1'b0;
      end
    end
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      cycles++;
      if (cycles > 40 * expected_count) begin
        $display("timeout: run hung after %0d cycles, %0d of %0d packets accepted",
                 cycles, accepted, expected_count);
        $display(">>> FAIL");
        $finish;
      end
    end
  end

  initial begin
    int total;
    clock            = 1'b0;
    reset            = 1'b1;
    pkt_ready        = 1'b0;
    redirect_valid   = 1'b0;
    redirect_pc      = '0;
    seed             = 42;
    accepted         = 0;
    cycles           = 0;
    redirect_num     = 0;
    wait_left        = 0;
    redirect_pending = 1'b0;
    redirect_target  = '0;
    stalled          = 1'b0;
    stalled_pkt      = '0;
    pc_errors        = 0;
    inst_errors      = 0;
    class_errors     = 0;
    hold_errors      = 0;
    count_errors     = 0;
    $readmemh("sim/prog.hex", prog);
    expected_count = count_expected();
    exp_pc = `FETCH_RESET_ADDR;
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
    while (accepted < expected_count) begin
      @(posedge clock);
      check_edge();
      #1 drive_inputs();
    end
    repeat (20) begin  // nothing more may come out
      @(posedge clock);
      check_edge();
      #1 drive_inputs();
    end
    assert (accepted == expected_count) else begin
      count_errors++;
      $display("packet count wrong: %0d accepted, %0d expected", accepted, expected_count);
    end
    total = pc_errors + inst_errors + class_errors + hold_errors + count_errors +
            uut.u_if_stage.u_chk.assert_errors;
    $display("errors: pc=%0d inst=%0d class=%0d hold=%0d count=%0d chk=%0d (packets %0d)",
             pc_errors, inst_errors, class_errors, hold_errors, count_errors,
             uut.u_if_stage.u_chk.assert_errors, accepted);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim/prog.hex
// one 32-bit word per line, word 0 at byte address 0
// low half-word is the lower address
00100093
01050085
00930085
A0010010
0000006F
00010001
00010001
00010001
00930001
C0010010
00630085
00010000
00010001
01050001
00100093
90828082
00010001
0000000F
00000073
00010001

// File: src/fetch_pkg.sv
package fetch_pkg;

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] word_t;  // memory word
  typedef logic [15:0] half_t;  // instruction parcel

  // master to slave
  typedef struct packed {
    logic  psel;
    logic  penable;
    addr_t paddr;
  } apb_req_t;

  // slave to master
  typedef struct packed {
    word_t prdata;
    logic  pready;
  } apb_rsp_t;

  typedef struct packed {
    addr_t pc;
    word_t inst;     // zero-extended when compressed
    logic  is_rv16;
    logic  is_cf;    // fetch stops behind this one
  } fetch_pkt_t;

  typedef enum logic [2:0] {
    IF_RESET,
    IF_ISSUE,
    IF_ACCESS,
    IF_PUSH,
    IF_HAZARD
  } if_state_e;

endpackage

// File: src/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue #(
  parameter int depth = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  push_valid,
  input  fetch_pkg::fetch_pkt_t push_pkt,
  output logic                  full,
  output fetch_pkg::fetch_pkt_t pkt,
  output logic                  pkt_valid,
  input  logic                  pkt_ready
);
  import fetch_pkg::*;

  localparam int pw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);
  localparam logic [pw-1:0] last_slot = pw'(depth - 1);
  localparam logic [cw-1:0] max_count = cw'(depth);

  fetch_pkt_t    slots [depth];
  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic [cw-1:0] count;
  logic          push;
  logic          pop;

  assign push      = push_valid && !full;
  assign pop       = pkt_valid && pkt_ready;
  assign full      = count == max_count;
  assign pkt_valid = count != '0;
  assign pkt       = slots[rd_ptr];  // head entry, stable until popped

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      slots[wr_ptr] <= push_pkt;
    end
  end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_top (
  input  logic                  clock,
  input  logic                  reset,
  output fetch_pkg::fetch_pkt_t pkt,
  output logic                  pkt_valid,
  input  logic                  pkt_ready,
  input  logic                  redirect_valid,
  input  fetch_pkg::addr_t      redirect_pc
);
  import fetch_pkg::*;

  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  word_t      raw_inst;
  logic       is_rv16;
  logic       is_cf;
  logic       push_valid;
  fetch_pkt_t push_pkt;
  logic       full;

  if_stage u_if_stage (
    .clock          (clock),
    .reset          (reset),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .raw_inst       (raw_inst),
    .is_rv16        (is_rv16),
    .is_cf          (is_cf),
    .push_valid     (push_valid),
    .push_pkt       (push_pkt),
    .full           (full),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  rvc_predecode u_predecode (
    .inst    (raw_inst),
    .is_rv16 (is_rv16),
    .is_cf   (is_cf)
  );

  fetch_queue #(
    .depth (`FQ_DEPTH)
  ) u_queue (
    .clock      (clock),
    .reset      (reset),
    .push_valid (push_valid),
    .push_pkt   (push_pkt),
    .full       (full),
    .pkt        (pkt),
    .pkt_valid  (pkt_valid),
    .pkt_ready  (pkt_ready)
  );

  itcm_apb #(
    .wait_cycles (`ITCM_WAIT),
    .words       (`ITCM_WORDS)
  ) u_itcm (
    .clock   (clock),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

endmodule

// File: src/if_stage.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module if_stage (
  input  logic                  clock,
  input  logic                  reset,
  output fetch_pkg::apb_req_t   apb_req,
  input  fetch_pkg::apb_rsp_t   apb_rsp,
  output fetch_pkg::word_t      raw_inst,
  input  logic                  is_rv16,
  input  logic                  is_cf,
  output logic                  push_valid,
  output fetch_pkg::fetch_pkt_t push_pkt,
  input  logic                  full,
  input  logic                  redirect_valid,
  input  fetch_pkg::addr_t      redirect_pc
);
  import fetch_pkg::*;

  localparam addr_t reset_addr = `FETCH_RESET_ADDR;

  if_state_e state;
  addr_t     pc_q;          // pc of the instruction being built
  addr_t     fetch_addr_q;  // next word to read
  half_t     hold_q;        // upper half of the last word read
  logic      hold_valid_q;
  logic      gap_q;         // idle cycle between back-to-back reads
  half_t     lo_half;
  half_t     hi_half;
  logic      need_read;
  logic      read_done;
  logic      take_pkt;

  // a compressed instruction sitting in hold_q needs no bus access
  assign need_read = !(pc_q[1] && hold_valid_q && (hold_q[1:0] != 2'b11));
  assign read_done = (state == IF_ACCESS) && apb_rsp.pready;

  always_comb begin
    if (pc_q[1]) begin
      lo_half = hold_valid_q ? hold_q : apb_rsp.prdata[31:16];
      hi_half = apb_rsp.prdata[15:0];
    end else begin
      lo_half = apb_rsp.prdata[15:0];
      hi_half = apb_rsp.prdata[31:16];
    end
    raw_inst = (lo_half[1:0] == 2'b11) ? {hi_half, lo_half} : {16'b0, lo_half};
  end

  // a half-word target that starts a 32-bit instruction waits for one more word
  assign take_pkt = (read_done && !(pc_q[1] && !hold_valid_q && !is_rv16)) ||
                    ((state == IF_ISSUE) && !gap_q && !need_read);

  always_comb begin
    apb_req.psel    = (state == IF_ACCESS) ||
                      ((state == IF_ISSUE) && need_read && !gap_q);
    apb_req.penable = state == IF_ACCESS;
    apb_req.paddr   = fetch_addr_q;  // held until pready
  end

  assign push_valid = state == IF_PUSH;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= IF_RESET;
      pc_q         <= reset_addr;
      fetch_addr_q <= {reset_addr[31:2], 2'b00};
      hold_valid_q <= 1'b0;
      gap_q        <= 1'b0;
    end else begin
      unique case (state)
        IF_RESET: begin
          state <= IF_ISSUE;
        end
        IF_ISSUE: begin
          gap_q <= 1'b0;
          if (gap_q) begin
            state <= IF_ISSUE;
          end else if (need_read) begin
            state <= IF_ACCESS;  // setup cycle on the bus
          end else begin
            state <= IF_PUSH;
          end
        end
        IF_ACCESS: begin
          if (apb_rsp.pready) begin
            fetch_addr_q <= fetch_addr_q + 32'd4;
            hold_valid_q <= 1'b1;
            if (take_pkt) begin
              state <= IF_PUSH;
            end else begin
              state <= IF_ISSUE;
              gap_q <= 1'b1;
            end
          end
        end
        IF_PUSH: begin
          if (!full) begin
            state <= push_pkt.is_cf ? IF_HAZARD : IF_ISSUE;
          end
        end
        IF_HAZARD: begin
          if (redirect_valid) begin
            pc_q         <= redirect_pc;
            fetch_addr_q <= {redirect_pc[31:2], 2'b00};
            hold_valid_q <= 1'b0;  // stale parcel
            state        <= IF_ISSUE;
          end
        end
        default: begin
          state <= IF_RESET;
        end
      endcase
      if (take_pkt) begin
        pc_q <= pc_q + (is_rv16 ? 32'd2 : 32'd4);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (read_done) begin
      hold_q <= apb_rsp.prdata[31:16];
    end
    if (take_pkt) begin
      push_pkt <= '{pc: pc_q, inst: raw_inst, is_rv16: is_rv16, is_cf: is_cf};
    end
  end

endmodule

// File: src/itcm_apb.sv
`timescale 1ns/10ps

module itcm_apb #(
  parameter int wait_cycles = 1,
  parameter int words = 64
) (
  input  logic                clock,
  input  logic                reset,
  input  fetch_pkg::apb_req_t apb_req,
  output fetch_pkg::apb_rsp_t apb_rsp
);
  import fetch_pkg::*;

  localparam int aw = (words > 1) ? $clog2(words) : 1;
  localparam int cw = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
  localparam logic [cw-1:0] wait_last = cw'(wait_cycles);

  word_t         mem [words];
  logic [cw-1:0] wait_cnt;
  logic          access;
  logic          ready;
  logic [aw-1:0] index;

  initial begin
    $readmemh("prog.hex", mem);
  end

  assign access = apb_req.psel && apb_req.penable;
  assign index  = apb_req.paddr[aw+1:2];  // word index, byte bits dropped
  assign ready  = access && (wait_cnt == wait_last);

  // counts access cycles of the current transfer
  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (access) begin
      if (wait_cnt == wait_last) begin
        wait_cnt <= '0;  // transfer ends, ready for next one
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    apb_rsp.pready = ready;
    apb_rsp.prdata = ready ? mem[index] : '0;
  end

endmodule

// File: src/rvc_predecode.sv
`timescale 1ns/10ps

module rvc_predecode (
  input  fetch_pkg::word_t inst,
  output logic             is_rv16,
  output logic             is_cf
);
  import fetch_pkg::*;

  // 32-bit major opcodes that end a fetch run
  localparam logic [6:0] op_jal      = 7'b1101111;
  localparam logic [6:0] op_jalr     = 7'b1100111;
  localparam logic [6:0] op_branch   = 7'b1100011;
  localparam logic [6:0] op_misc_mem = 7'b0001111;  // fence, fence.i
  localparam logic [6:0] op_system   = 7'b1110011;  // ecall, ebreak, csr

  half_t      c_inst;
  logic [1:0] quadrant;
  logic [2:0] funct3;
  logic [3:0] funct4;
  logic [6:0] opcode;
  logic       cf32;
  logic       cf16;

  assign c_inst   = inst[15:0];
  assign quadrant = c_inst[1:0];
  assign funct3   = c_inst[15:13];
  assign funct4   = c_inst[15:12];
  assign opcode   = inst[6:0];

  assign cf32 = opcode inside {op_jal, op_jalr, op_branch, op_misc_mem, op_system};

  always_comb begin
    case (quadrant)
      // c.jal, c.j, c.beqz, c.bnez
      2'b01: cf16 = funct3 inside {3'b001, 3'b101, 3'b110, 3'b111};
      // c.jr, c.jalr, c.ebreak share rs2 == 0
      2'b10: cf16 = (funct4 inside {4'b1000, 4'b1001}) && (c_inst[6:2] == 5'd0);
      default: cf16 = 1'b0;
    endcase
  end

  assign is_rv16 = quadrant != 2'b11;
  assign is_cf   = is_rv16 ? cf16 : cf32;

endmodule
